// ==== verilog/stash_defines.svh ====
`ifndef STASH_DEFINES_SVH
`define STASH_DEFINES_SVH

// ------------------------------------------------------------------------
// Store geometry
// ------------------------------------------------------------------------

// Number of entries in the shift register
`define STASH_DEPTH 8

// Key and value widths in bits
`define STASH_KEY_W 8
`define STASH_VALUE_W 16

// ------------------------------------------------------------------------
// Register block
// ------------------------------------------------------------------------

`define STASH_APB_AW 8

`endif

// ==== verilog/stash_pkg.sv ====
`default_nettype none

`include "stash_defines.svh"

package stash_pkg;

    typedef logic [`STASH_KEY_W-1:0]             key_t;
    typedef logic [`STASH_VALUE_W-1:0]           value_t;
    // Needs to hold 0 through the full depth
    typedef logic [$clog2(`STASH_DEPTH+1)-1:0]   fill_t;

    typedef struct packed {
        key_t   key;
        logic   valid;
        value_t value;
    } entry_t;

    // op: 0 push, 1 pop
    typedef struct packed {
        logic   op;
        entry_t entry;
    } wr_req_t;

    // op: 0 lookup by key, 1 peek at oldest
    typedef struct packed {
        logic op;
        key_t key;
    } rd_req_t;

    typedef struct packed {
        logic   hit;
        entry_t entry;
        logic   error;
    } rd_resp_t;

    typedef struct packed {
        fill_t fill;
        logic  empty;
        logic  full;
        logic  init_done;
    } store_status_t;

endpackage : stash_pkg

`default_nettype wire

// ==== verilog/stash_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "stash_defines.svh"

module stash_regs (
    input  logic                     clk,
    input  logic                     __srst,

    // APB slave
    input  logic [`STASH_APB_AW-1:0] paddr,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  logic [31:0]              pwdata,
    output logic [31:0]              prdata,
    output logic                     pready,
    output logic                     pslverr,

    // From store
    input  stash_pkg::store_status_t status,
    input  logic                     push_drop,

    // To store
    output logic                     flush
);

    // ------------------------------------------------------------------------
    // Register map
    // ------------------------------------------------------------------------
    localparam logic [`STASH_APB_AW-1:0] ADDR_CTRL     = 'h0;
    localparam logic [`STASH_APB_AW-1:0] ADDR_STATUS   = 'h4;
    localparam logic [`STASH_APB_AW-1:0] ADDR_INFO     = 'h8;
    localparam logic [`STASH_APB_AW-1:0] ADDR_DROP_CNT = 'hC;

    // ------------------------------------------------------------------------
    // Signals
    // ------------------------------------------------------------------------
    logic        access;
    logic        wr_en;
    logic        sel_ctrl;
    logic        sel_status;
    logic        sel_info;
    logic        sel_drop;
    logic        addr_ok;
    logic [15:0] drop_cnt;

    // ------------------------------------------------------------------------
    // Decode
    // ------------------------------------------------------------------------

    // Zero wait states, every transfer ends in its access phase
    assign pready = 1'b1;

    assign access = psel && penable;
    assign wr_en  = access && pwrite;

    assign sel_ctrl   = (paddr == ADDR_CTRL);
    assign sel_status = (paddr == ADDR_STATUS);
    assign sel_info   = (paddr == ADDR_INFO);
    assign sel_drop   = (paddr == ADDR_DROP_CNT);
    assign addr_ok    = sel_ctrl || sel_status || sel_info || sel_drop;

    assign pslverr = access && !addr_ok;

    // Read mux
    always_comb begin
        prdata = '0;
        if (sel_status) begin
            prdata[3:0] = status.fill;
            prdata[4]   = status.empty;
            prdata[5]   = status.full;
            prdata[6]   = status.init_done;
        end else if (sel_info) begin
            prdata = 32'(`STASH_DEPTH);
        end else if (sel_drop) begin
            prdata[15:0] = drop_cnt;
        end
    end

    // ------------------------------------------------------------------------
    // Flush pulse
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (__srst) begin
            flush <= 1'b0;
        end else begin
            flush <= wr_en && sel_ctrl && pwdata[0];
        end
    end

    // ------------------------------------------------------------------------
    // Drop counter
    // ------------------------------------------------------------------------

    // Write clears, otherwise count up and stick at max
    always_ff @(posedge clk) begin
        if (__srst) begin
            drop_cnt <= '0;
        end else if (wr_en && sel_drop) begin
            drop_cnt <= '0;
        end else if (push_drop && (drop_cnt != '1)) begin
            drop_cnt <= drop_cnt + 1'b1;
        end
    end

endmodule : stash_regs

`default_nettype wire

// ==== verilog/stash_store.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "stash_defines.svh"

module stash_store (
    input  logic                     clk,
    input  logic                     __srst,
    input  logic                     flush,

    // Write port
    input  logic                     wr_req,
    input  stash_pkg::wr_req_t       wr_data,
    output logic                     wr_rdy,
    output logic                     wr_ack,
    output logic                     wr_error,

    // Read port
    input  logic                     rd_req,
    input  stash_pkg::rd_req_t       rd_data,
    output logic                     rd_rdy,
    output logic                     rd_ack,
    output stash_pkg::rd_resp_t      rd_resp,

    // To register block
    output stash_pkg::store_status_t status,
    output logic                     push_drop
);

    import stash_pkg::*;

    localparam int IDX_W = $clog2(`STASH_DEPTH);

    typedef logic [IDX_W-1:0] idx_t;

    // ------------------------------------------------------------------------
    // Signals
    // ------------------------------------------------------------------------
    logic                    local_srst;
    logic                    init_done;

    // Slot 0 is the head and holds the newest entry
    entry_t                  entries [`STASH_DEPTH];
    logic [`STASH_DEPTH-1:0] occ;
    fill_t                   fill;

    logic                    full;
    logic                    empty;

    logic                    wr_acc;
    logic                    rd_acc;
    logic                    push_ok;
    logic                    pop_ok;

    idx_t                    tail_idx;
    logic                    match;
    idx_t                    match_idx;
    rd_resp_t                rd_next;

    // ------------------------------------------------------------------------
    // Local reset and init done
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        local_srst <= __srst || flush;
    end

    // Cleared together with the local reset so rdy never overlaps it
    always_ff @(posedge clk) begin
        if (__srst || flush || local_srst) begin
            init_done <= 1'b0;
        end else begin
            init_done <= 1'b1;
        end
    end

    assign wr_rdy = init_done;
    assign rd_rdy = init_done;

    assign wr_acc = wr_req && wr_rdy;
    assign rd_acc = rd_req && rd_rdy;

    // ------------------------------------------------------------------------
    // Fill tracking
    // ------------------------------------------------------------------------
    assign full  = (fill == fill_t'(`STASH_DEPTH));
    assign empty = (fill == '0);

    assign push_ok = wr_acc && !wr_data.op && !full;
    assign pop_ok  = wr_acc && wr_data.op && !empty;

    // Oldest slot, don't care when empty
    assign tail_idx = idx_t'(fill - 1'b1);

    always_ff @(posedge clk) begin
        if (local_srst) begin
            fill <= '0;
            occ  <= '0;
        end else if (push_ok) begin
            fill <= fill + 1'b1;
            occ  <= {occ[`STASH_DEPTH-2:0], 1'b1};
        end else if (pop_ok) begin
            fill          <= fill - 1'b1;
            occ[tail_idx] <= 1'b0;
        end
    end

    // Push shifts everything toward the tail
    always_ff @(posedge clk) begin
        if (push_ok) begin
            for (int i = `STASH_DEPTH-1; i > 0; i--) begin
                entries[i] <= entries[i-1];
            end
            entries[0] <= wr_data.entry;
        end
    end

    // ------------------------------------------------------------------------
    // Key search
    // ------------------------------------------------------------------------

    // Lowest matching slot wins, which is the newest
    always_comb begin
        match     = 1'b0;
        match_idx = '0;
        for (int i = `STASH_DEPTH-1; i >= 0; i--) begin
            if (occ[i] && (entries[i].key == rd_data.key)) begin
                match     = 1'b1;
                match_idx = idx_t'(i);
            end
        end
    end

    always_comb begin
        rd_next = '0;
        if (rd_data.op) begin
            // Peek
            rd_next.hit   = !empty;
            rd_next.error = empty;
            if (!empty) begin
                rd_next.entry = entries[tail_idx];
            end
        end else if (match) begin
            rd_next.hit   = 1'b1;
            rd_next.entry = entries[match_idx];
        end
    end

    // ------------------------------------------------------------------------
    // Acknowledge
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (__srst) begin
            wr_ack    <= 1'b0;
            rd_ack    <= 1'b0;
            push_drop <= 1'b0;
        end else begin
            wr_ack    <= wr_acc;
            rd_ack    <= rd_acc;
            push_drop <= wr_acc && !wr_data.op && full;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_acc) begin
            wr_error <= wr_data.op ? empty : full;
        end
        if (rd_acc) begin
            rd_resp <= rd_next;
        end
    end

    // ------------------------------------------------------------------------
    // Status
    // ------------------------------------------------------------------------
    assign status.fill      = fill;
    assign status.empty     = empty;
    assign status.full      = full;
    assign status.init_done = init_done;

endmodule : stash_store

`default_nettype wire

// ==== verilog/stash_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "stash_defines.svh"

module stash_top (
    input  logic                     clk,
    input  logic                     __srst,

    // APB slave
    input  logic [`STASH_APB_AW-1:0] paddr,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  logic [31:0]              pwdata,
    output logic [31:0]              prdata,
    output logic                     pready,
    output logic                     pslverr,

    // Write port
    input  logic                     wr_req,
    input  stash_pkg::wr_req_t       wr_data,
    output logic                     wr_rdy,
    output logic                     wr_ack,
    output logic                     wr_error,

    // Read port
    input  logic                     rd_req,
    input  stash_pkg::rd_req_t       rd_data,
    output logic                     rd_rdy,
    output logic                     rd_ack,
    output stash_pkg::rd_resp_t      rd_resp
);

    import stash_pkg::*;

    // Between register block and store
    logic          flush;
    store_status_t status;
    logic          push_drop;

    stash_regs i_stash_regs (
        .clk       (clk),
        .__srst    (__srst),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .status    (status),
        .push_drop (push_drop),
        .flush     (flush)
    );

    stash_store i_stash_store (
        .clk       (clk),
        .__srst    (__srst),
        .flush     (flush),
        .wr_req    (wr_req),
        .wr_data   (wr_data),
        .wr_rdy    (wr_rdy),
        .wr_ack    (wr_ack),
        .wr_error  (wr_error),
        .rd_req    (rd_req),
        .rd_data   (rd_data),
        .rd_rdy    (rd_rdy),
        .rd_ack    (rd_ack),
        .rd_resp   (rd_resp),
        .status    (status),
        .push_drop (push_drop)
    );

endmodule : stash_top

`default_nettype wire

// ==== bench/stash_clkgen.sv ====
`timescale 1ns/1ps
`default_nettype none

module stash_clkgen (
    output logic clk,
    output logic __srst
);

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Five rising edges in reset, released on a falling edge
    initial begin
        __srst = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        __srst = 1'b0;
    end

endmodule : stash_clkgen

`default_nettype wire

// ==== bench/stash_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "stash_defines.svh"

module stash_sva (
    input logic                    clk,
    input logic                    __srst,
    input logic                    local_srst,
    input logic                    wr_req,
    input logic                    wr_rdy,
    input logic                    wr_ack,
    input logic                    rd_req,
    input logic                    rd_rdy,
    input logic                    rd_ack,
    input stash_pkg::fill_t        fill,
    input logic [`STASH_DEPTH-1:0] occ,
    input logic                    empty,
    input logic                    full
);

    import stash_pkg::*;

    // ------------------------------------------------------------------------
    // Handshake
    // ------------------------------------------------------------------------
    a_wr_ack: assert property (@(posedge clk) disable iff (__srst)
        (wr_req && wr_rdy) |=> wr_ack) else $error("write accept without ack");
    a_rd_ack: assert property (@(posedge clk) disable iff (__srst)
        (rd_req && rd_rdy) |=> rd_ack) else $error("read accept without ack");
    a_wr_spurious: assert property (@(posedge clk) disable iff (__srst)
        !(wr_req && wr_rdy) |=> !wr_ack) else $error("write ack without accept");
    a_rd_spurious: assert property (@(posedge clk) disable iff (__srst)
        !(rd_req && rd_rdy) |=> !rd_ack) else $error("read ack without accept");

    // ------------------------------------------------------------------------
    // Fill and local reset
    // ------------------------------------------------------------------------
    a_fill_max: assert property (@(posedge clk) disable iff (__srst)
        fill <= fill_t'(`STASH_DEPTH)) else $error("fill above depth");
    a_flags: assert property (@(posedge clk) disable iff (__srst)
        (empty == (occ == '0)) && (full == (&occ)))
        else $error("empty/full disagree with occupancy");
    a_rdy_in_reset: assert property (@(posedge clk)
        local_srst |-> (!wr_rdy && !rd_rdy)) else $error("rdy high in local reset");

endmodule : stash_sva

bind stash_store stash_sva sva0 (
    .clk        (clk),
    .__srst     (__srst),
    .local_srst (local_srst),
    .wr_req     (wr_req),
    .wr_rdy     (wr_rdy),
    .wr_ack     (wr_ack),
    .rd_req     (rd_req),
    .rd_rdy     (rd_rdy),
    .rd_ack     (rd_ack),
    .fill       (fill),
    .occ        (occ),
    .empty      (empty),
    .full       (full)
);

`default_nettype wire

// ==== bench/stash_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "stash_defines.svh"

module stash_tb;

    import stash_pkg::*;

    localparam int          RESET_TIMEOUT = 20;
    localparam int          RDY_TIMEOUT   = 10;
    localparam int          FLUSH_BOUND   = 3;
    localparam int          ACK_TIMEOUT   = 4;
    localparam int          APB_TIMEOUT   = 4;
    localparam int          RANDOM_OPS    = 300;
    localparam logic [31:0] SEED          = 32'd72;

    logic                     clk;
    logic                     __srst;
    logic [`STASH_APB_AW-1:0] paddr;
    logic                     psel, penable, pwrite, pready, pslverr;
    logic [31:0]              pwdata, prdata;
    logic                     wr_req, wr_rdy, wr_ack, wr_error;
    wr_req_t                  wr_data;
    logic                     rd_req, rd_rdy, rd_ack;
    rd_req_t                  rd_data;
    rd_resp_t                 rd_resp;

    // Reference store with the newest entry at index 0
    entry_t      model_q[$];
    int          model_drops;
    int          value_errs;
    int          timeouts;
    logic [31:0] rng;

    stash_clkgen clkgen0 (.clk(clk), .__srst(__srst));

    stash_top dut0 (.*);

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------
    task automatic finish_run();
        $display("Errors: %0d value, %0d timeout", value_errs, timeouts);
        if ((value_errs == 0) && (timeouts == 0)) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        assert (got === exp) else begin
            value_errs++;
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    function automatic logic [31:0] next_rand();
        rng ^= rng << 13;
        rng ^= rng >> 17;
        rng ^= rng << 5;
        return rng;
    endfunction

    function automatic wr_req_t make_wr(logic op, key_t k, value_t v, logic vld);
        wr_req_t w;
        w.op          = op;
        w.entry.key   = k;
        w.entry.valid = vld;
        w.entry.value = v;
        return w;
    endfunction

    function automatic rd_req_t make_rd(logic op, key_t k);
        rd_req_t r;
        r.op  = op;
        r.key = k;
        return r;
    endfunction

    function automatic logic [31:0] expected_status();
        int n;
        n = model_q.size();
        return {25'd0, 1'b1, n == `STASH_DEPTH, n == 0, 4'(n)};
    endfunction

    // Peek takes the oldest and lookup the newest match
    function automatic rd_resp_t predict_read(rd_req_t r);
        rd_resp_t resp;
        resp = '0;
        if (r.op) begin
            resp.error = (model_q.size() == 0);
            if (model_q.size() != 0) begin
                resp.hit   = 1'b1;
                resp.entry = model_q[model_q.size() - 1];
            end
        end else begin
            for (int i = model_q.size() - 1; i >= 0; i--) begin
                if (model_q[i].key == r.key) begin
                    resp.hit   = 1'b1;
                    resp.entry = model_q[i];
                end
            end
        end
        return resp;
    endfunction

    task automatic wait_rdy(input logic level, input int limit, input string what);
        int n;
        n = 0;
        while (((wr_rdy !== level) || (rd_rdy !== level)) && (timeouts == 0)) begin
            if (n >= limit) begin
                timeouts++;
                $display("Timeout while waiting for %s", what);
            end else begin
                @(negedge clk);
                n++;
            end
        end
    endtask

    task automatic wait_ack(input logic need_wr, input logic need_rd);
        int n;
        n = 0;
        @(negedge clk);
        wr_req = 1'b0;
        rd_req = 1'b0;
        while (((need_wr && !wr_ack) || (need_rd && !rd_ack)) && (timeouts == 0)) begin
            if (n >= ACK_TIMEOUT) begin
                timeouts++;
                $display("Timeout while waiting for the write or read ack");
            end else begin
                @(negedge clk);
                n++;
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // Application and APB transfers
    // ------------------------------------------------------------------------
    task automatic transact(input logic do_wr, input wr_req_t w,
                            input logic do_rd, input rd_req_t r);
        logic     exp_err;
        rd_resp_t exp_resp;
        exp_err = 1'b0;
        wait_rdy(1'b1, RDY_TIMEOUT, "write and read ready");
        // Read sees the contents before this cycle's write
        exp_resp = predict_read(r);
        if (do_wr && !w.op) begin
            exp_err = (model_q.size() == `STASH_DEPTH);
            if (exp_err) begin
                model_drops++;
            end else begin
                model_q.push_front(w.entry);
            end
        end else if (do_wr) begin
            exp_err = (model_q.size() == 0);
            if (!exp_err) begin
                void'(model_q.pop_back());
            end
        end
        wr_req  = do_wr;
        wr_data = w;
        rd_req  = do_rd;
        rd_data = r;
        wait_ack(do_wr, do_rd);
        if (do_wr) begin
            check_value(32'(wr_error), 32'(exp_err), "write error flag");
        end
        if (do_rd) begin
            check_value(32'(rd_resp), 32'(exp_resp), "read response");
        end
    endtask

    task automatic apb_access(input logic write, input logic [7:0] addr,
                              input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        int n;
        paddr   = addr;
        pwrite  = write;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        #1;
        n = 0;
        while (!pready && (timeouts == 0)) begin
            if (n >= APB_TIMEOUT) begin
                timeouts++;
                $display("Timeout while waiting for pready");
            end else begin
                @(negedge clk);
                #1;
                n++;
            end
        end
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic check_reg(input logic [7:0] addr, input logic [31:0] exp,
                             input string what);
        logic [31:0] data;
        logic        err;
        apb_access(1'b0, addr, '0, data, err);
        check_value(data, exp, what);
        check_value(32'(err), 32'd0, {what, " slave error"});
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] wdata);
        logic [31:0] data;
        logic        err;
        apb_access(1'b1, addr, wdata, data, err);
        check_value(32'(err), 32'd0, "register write slave error");
    endtask

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin
        logic [31:0] data;
        logic        err;
        logic [31:0] a;
        logic [31:0] b;
        int          n;
        value_errs  = 0;
        timeouts    = 0;
        model_drops = 0;
        rng         = SEED;
        paddr       = '0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        pwdata      = '0;
        wr_req      = 1'b0;
        wr_data     = '0;
        rd_req      = 1'b0;
        rd_data     = '0;

        // Reset changes on the falling edge and is sampled on the rising one
        n = 0;
        @(posedge clk);
        while (__srst && (timeouts == 0)) begin
            if (n >= RESET_TIMEOUT) begin
                timeouts++;
                $display("Timeout while waiting for reset release");
            end else begin
                @(posedge clk);
                n++;
            end
        end
        @(negedge clk);
        wait_rdy(1'b1, RDY_TIMEOUT, "ready after reset");

        check_reg(8'h04, expected_status(), "STATUS after reset");
        check_reg(8'h08, 32'(`STASH_DEPTH), "INFO");
        apb_access(1'b0, 8'h10, '0, data, err);
        check_value(32'(err), 32'd1, "slave error on unused address");
        check_value(data, 32'd0, "read data on unused address");

        // Keys repeat every five pushes and the last two overflow
        for (int i = 0; i < `STASH_DEPTH + 2; i++) begin
            transact(1'b1, make_wr(1'b0, key_t'(i % 5), value_t'(16'h1000 + i), i[0]),
                     1'b0, make_rd(1'b0, '0));
        end
        check_reg(8'h04, expected_status(), "STATUS when full");
        check_reg(8'h0C, 32'(model_drops), "DROP_CNT after overflow");

        for (int i = 0; i < 5; i++) begin
            transact(1'b0, make_wr(1'b0, '0, '0, 1'b0), 1'b1, make_rd(1'b0, key_t'(i)));
        end
        transact(1'b0, make_wr(1'b0, '0, '0, 1'b0), 1'b1, make_rd(1'b0, 8'h77));

        // Peek keeps fill and each pop of the drain is followed by a peek
        transact(1'b0, make_wr(1'b0, '0, '0, 1'b0), 1'b1, make_rd(1'b1, '0));
        check_reg(8'h04, expected_status(), "STATUS after peek");
        for (int i = 0; i < `STASH_DEPTH; i++) begin
            transact(1'b1, make_wr(1'b1, '0, '0, 1'b0), 1'b0, make_rd(1'b0, '0));
            transact(1'b0, make_wr(1'b0, '0, '0, 1'b0), 1'b1, make_rd(1'b1, '0));
        end
        transact(1'b1, make_wr(1'b1, '0, '0, 1'b0), 1'b0, make_rd(1'b0, '0));

        // Back-to-back random mix with pushes slightly favoured
        for (int i = 0; i < RANDOM_OPS; i++) begin
            a = next_rand();
            b = next_rand();
            transact(a[8] | a[9], make_wr(a[3:0] < 4'd7, key_t'(a[6:4]), a[31:16], a[7]),
                     b[5] | b[6], make_rd(b[1:0] == 2'b00, key_t'(b[4:2])));
        end

        // Flush empties the store and keeps the drop count
        write_reg(8'h00, 32'd1);
        wait_rdy(1'b0, FLUSH_BOUND, "ready low after flush");
        wait_rdy(1'b1, FLUSH_BOUND, "ready high after flush");
        model_q.delete();
        check_reg(8'h04, expected_status(), "STATUS after flush");
        check_reg(8'h0C, 32'(model_drops), "DROP_CNT after flush");
        write_reg(8'h0C, 32'd0);
        check_reg(8'h0C, 32'd0, "DROP_CNT after clear");

        finish_run();
    end

endmodule : stash_tb

`default_nettype wire

// ==== stash_fifo.f ====
+incdir+verilog
verilog/stash_pkg.sv
verilog/stash_regs.sv
verilog/stash_store.sv
verilog/stash_top.sv
bench/stash_clkgen.sv
bench/stash_sva.sv
bench/stash_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the stash testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f stash_fifo.f --top-module stash_tb -Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/Vstash_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
    echo "Failure reported in $LOG"
    exit 1
fi
exit 0
